//--- verif/fir_input.txt
// FIR stimulus, hex words in order, a sample's top digit is its last flag
// per run: 11 taps, then input samples, then expected outputs
// run A taps
00000001 00000002 00000003 00000004 00000005 00000006 00000007 00000008 00000009 0000000a 0000000b
// run A samples
000000001 000000002 000000003 000000004 000000005 000000006 000000007
000000008 000000009 00000000a 00000000b 00000000c 00000000d 10000000e
// run A expected outputs
00000001 00000004 0000000a 00000014 00000023 00000038 00000054
00000078 000000a5 000000dc 0000011e 00000160 000001a2 000001e4
// run B taps
ffffffff 00000003 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00010000
// run B samples
000000005 0fffffffe 000010000 07fffffff 000000000 000000001
0ffffffff 000000010 000000002 000000003 000000004 100010001
// run B expected outputs
fffffffb 00000011 fffefffa 80030001 7ffffffd ffffffff
00000004 ffffffed 0000002e 00000003 00050005 fffd000b

//--- flist.f
common/fir_pkg.sv
logic/axil_slave.sv
logic/cfg_regs.sv
logic/tap_arbiter.sv
fir_engine/fir_engine.sv
logic/fir_top.sv
verif/bram_model.sv
verif/fir_tb.sv

//--- Makefile
# Verilator build and run for the FIR testbench

VERILATOR ?= verilator
TOP       ?= fir_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing
PASS_MSG  ?= ALL TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- verif/fir_tb.sv
/* FIR testbench with AXI-Lite and stream drivers, file-driven stimulus
   and expected outputs, per-test report and cycle watchdog */
`timescale 1ns/1ps
`default_nettype none

module fir_tb;
    import fir_pkg::*;

    // word offsets inside the data file
    localparam int SAMP_A     = 14;
    localparam int SAMP_B     = 12;
    localparam int TAPS_A     = 0;
    localparam int XIN_A      = TAPS_A + NUM_TAPS;
    localparam int EXP_A      = XIN_A + SAMP_A;
    localparam int TAPS_B     = EXP_A + SAMP_A;
    localparam int XIN_B      = TAPS_B + NUM_TAPS;
    localparam int EXP_B      = XIN_B + SAMP_B;
    localparam int STIM_WORDS = EXP_B + SAMP_B;
    // run A is streamed twice
    localparam int TOTAL_SAMPLES = 2 * SAMP_A + SAMP_B;
    localparam int CYCLE_LIMIT   = TOTAL_SAMPLES * (NUM_TAPS + 2) * 4 + 2000;

    logic  axis_clk;
    logic  axis_rst_n;
    logic  awvalid;
    addr_t awaddr;
    logic  awready;
    logic  wvalid;
    data_t wdata;
    logic  wready;
    logic  arvalid;
    addr_t araddr;
    logic  arready;
    logic  rvalid;
    logic  rready;
    data_t rdata;
    logic  ss_tvalid;
    data_t ss_tdata;
    logic  ss_tlast;
    logic  ss_tready;
    logic  sm_tready;
    logic  sm_tvalid;
    data_t sm_tdata;
    logic  sm_tlast;
    logic  tap_we;
    addr_t tap_addr;
    data_t tap_wdata;
    data_t tap_rdata;
    logic  data_we;
    addr_t data_addr;
    data_t data_wdata;
    data_t data_rdata;

    // bit 32 of a sample word is its last flag
    logic [35:0] stim [0:STIM_WORDS-1];

    integer seed;
    int     cycle_cnt;
    int     sent_cnt;
    int     test_errs;
    int     total_errs;
    int     tests_run;
    int     tests_failed;

    fir_top fir_top_inst (.*);

    bram_model tap_ram_inst (
        .axis_clk (axis_clk),
        .we       (tap_we),
        .addr     (tap_addr),
        .wdata    (tap_wdata),
        .rdata    (tap_rdata)
    );

    bram_model data_ram_inst (
        .axis_clk (axis_clk),
        .we       (data_we),
        .addr     (data_addr),
        .wdata    (data_wdata),
        .rdata    (data_rdata)
    );

    initial begin
        axis_clk = 1'b0;
        forever #50 axis_clk = ~axis_clk;
    end

    initial begin : watchdog
        cycle_cnt = 0;
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge axis_clk);
            cycle_cnt = cycle_cnt + 1;
        end
        $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("SOME TESTS FAILED");
        $finish;
    end

    task automatic mismatch(input string sig, input data_t got, input data_t exp);
        $display("MISMATCH %s: got 0x%h expected 0x%h", sig, got, exp);
        test_errs = test_errs + 1;
    endtask

    task automatic failure(input string what);
        $display("ERROR: %s", what);
        test_errs = test_errs + 1;
    endtask

    task automatic start_test;
        test_errs = 0;
    endtask

    task automatic end_test(input string name);
        tests_run  = tests_run + 1;
        total_errs = total_errs + test_errs;
        if (test_errs == 0) begin
            $display("test %-24s passed", name);
        end else begin
            $display("test %-24s failed with %0d errors", name, test_errs);
            tests_failed = tests_failed + 1;
        end
    endtask

    // inputs change 1 ns after the rising edge
    task automatic next_cycle;
        @(posedge axis_clk);
        #1;
    endtask

    function automatic data_t ctrl_value(input logic start, input logic done, input logic idle);
        data_t w;
        w               = '0;
        w[AP_START_BIT] = start;
        w[AP_DONE_BIT]  = done;
        w[AP_IDLE_BIT]  = idle;
        return w;
    endfunction

    function automatic addr_t tap_offset(input int k);
        return ADDR_TAP_BASE + addr_t'(k * 4);
    endfunction

    task automatic axil_write(input addr_t addr, input data_t data);
        logic acked;
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        acked   = 1'b0;
        // outputs sampled on the falling edge, transfer on the next rising one
        while (!acked) begin
            @(negedge axis_clk);
            acked = awready && wready;
            next_cycle();
        end
        awvalid = 1'b0;
        wvalid  = 1'b0;
    endtask

    task automatic axil_read(input addr_t addr, output data_t data);
        logic acked;
        araddr  = addr;
        arvalid = 1'b1;
        acked   = 1'b0;
        data    = '0;
        while (!acked) begin
            @(negedge axis_clk);
            acked = arready;
            next_cycle();
        end
        arvalid = 1'b0;
        rready  = 1'b1;
        acked   = 1'b0;
        while (!acked) begin
            @(negedge axis_clk);
            acked = rvalid;
            data  = rdata;
            next_cycle();
        end
        rready = 1'b0;
    endtask

    task automatic check_ctrl(input logic start, input logic done, input logic idle);
        data_t rd;
        axil_read(ADDR_CTRL, rd);
        if (rd !== ctrl_value(start, done, idle)) begin
            mismatch("rdata (control)", rd, ctrl_value(start, done, idle));
        end
    endtask

    // write every tap, then read each one back
    task automatic load_taps(input int base);
        data_t rd;
        data_t tap;
        int    k;
        for (k = 0; k < NUM_TAPS; k++) begin
            axil_write(tap_offset(k), data_t'(stim[base + k][31:0]));
        end
        for (k = 0; k < NUM_TAPS; k++) begin
            tap = data_t'(stim[base + k][31:0]);
            axil_read(tap_offset(k), rd);
            if (rd !== tap) begin
                mismatch($sformatf("rdata (tap %0d)", k), rd, tap);
            end
        end
    endtask

    task automatic run_stream(input int xin_base, input int exp_base, input int n,
                              input logic stall);
        int    i;
        int    rcv;
        logic  taken;
        data_t rd;
        data_t exp;
        sent_cnt = 0;
        axil_write(ADDR_CTRL, ctrl_value(1'b1, 1'b0, 1'b0));
        fork
            begin : feed
                for (i = 0; i < n; i++) begin
                    if (stall) begin
                        while (($random(seed) & 3) == 0) begin
                            ss_tvalid = 1'b0;
                            next_cycle();
                        end
                    end
                    ss_tvalid = 1'b1;
                    ss_tdata  = data_t'(stim[xin_base + i][31:0]);
                    ss_tlast  = stim[xin_base + i][32];
                    taken     = 1'b0;
                    while (!taken) begin
                        @(negedge axis_clk);
                        taken = ss_tready;
                        next_cycle();
                    end
                    sent_cnt = sent_cnt + 1;
                end
                ss_tvalid = 1'b0;
                ss_tlast  = 1'b0;
            end
            begin : drain
                rcv = 0;
                while (rcv < n) begin
                    @(negedge axis_clk);
                    if (sm_tvalid && sm_tready) begin
                        exp = data_t'(stim[exp_base + rcv][31:0]);
                        if (sm_tdata !== exp) begin
                            mismatch($sformatf("sm_tdata[%0d]", rcv), sm_tdata, exp);
                        end
                        if (sm_tlast !== (rcv == n - 1)) begin
                            mismatch($sformatf("sm_tlast[%0d]", rcv), data_t'(sm_tlast),
                                     data_t'(rcv == n - 1));
                        end
                        rcv = rcv + 1;
                    end
                    next_cycle();
                    sm_tready = stall ? (($random(seed) & 3) != 0) : 1'b1;
                end
                sm_tready = 1'b1;
            end
            begin : busy_read
                // engine is mid-run once the first sample is in
                wait (sent_cnt >= 1);
                axil_read(ADDR_CTRL, rd);
                if (rd[AP_IDLE_BIT] !== 1'b0) begin
                    mismatch("ap_idle (streaming)", data_t'(rd[AP_IDLE_BIT]), '0);
                end
            end
        join
    endtask

    // done is set after the final output and cleared by the first read
    task automatic check_done;
        if (sm_tvalid) begin
            failure("output still valid after the final sample was taken");
        end
        check_ctrl(1'b0, 1'b1, 1'b1);
        check_ctrl(1'b0, 1'b0, 1'b1);
    endtask

    initial begin : main
        seed         = 32'hc97f8258;
        sent_cnt     = 0;
        test_errs    = 0;
        total_errs   = 0;
        tests_run    = 0;
        tests_failed = 0;
        axis_rst_n   = 1'b0;
        awvalid      = 1'b0;
        awaddr       = '0;
        wvalid       = 1'b0;
        wdata        = '0;
        arvalid      = 1'b0;
        araddr       = '0;
        rready       = 1'b0;
        ss_tvalid    = 1'b0;
        ss_tdata     = '0;
        ss_tlast     = 1'b0;
        sm_tready    = 1'b1;
        $readmemh("verif/fir_input.txt", stim);

        repeat (8) @(posedge axis_clk);
        #1;
        axis_rst_n = 1'b1;
        next_cycle();

        start_test();
        check_ctrl(1'b0, 1'b0, 1'b1);
        end_test("control after reset");

        start_test();
        load_taps(TAPS_A);
        end_test("tap readback, set A");

        start_test();
        run_stream(XIN_A, EXP_A, SAMP_A, 1'b0);
        end_test("stream A, no stalls");

        start_test();
        check_done();
        end_test("done clear, stream A");

        start_test();
        run_stream(XIN_A, EXP_A, SAMP_A, 1'b1);
        end_test("stream A, random stalls");

        start_test();
        check_done();
        end_test("done clear, stalled A");

        start_test();
        load_taps(TAPS_B);
        end_test("tap readback, set B");

        // fresh run, history must start from zero
        start_test();
        run_stream(XIN_B, EXP_B, SAMP_B, 1'b1);
        end_test("stream B, random stalls");

        start_test();
        check_done();
        end_test("done clear, stream B");

        $display("summary: %0d tests, %0d passed, %0d failed, %0d check errors",
                 tests_run, tests_run - tests_failed, tests_failed, total_errs);
        if (tests_failed == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/bram_model.sv
/* synchronous single-port RAM model with one-cycle read latency */
`timescale 1ns/1ps
`default_nettype none

module bram_model (
    input  logic           axis_clk,
    input  logic           we,
    input  fir_pkg::addr_t addr,
    input  fir_pkg::data_t wdata,
    output fir_pkg::data_t rdata
);
    import fir_pkg::*;

    // one word per 4-byte slot over the whole byte address range
    localparam int WORDS = 2 ** (ADDR_W - 2);

    data_t mem [0:WORDS-1];

    // nonzero fill, stale history would show up in the sums
    initial begin
        for (int i = 0; i < WORDS; i++) begin
            mem[i] = data_t'(32'h5a000000 | i);
        end
    end

    // read returns the old word on a write cycle
    always @(posedge axis_clk) begin
        rdata <= mem[addr[ADDR_W-1:2]];
        if (we) begin
            mem[addr[ADDR_W-1:2]] = wdata;
        end
    end

endmodule

`default_nettype wire

//--- logic/fir_top.sv
/* FIR top level, AXI-Lite config path and FIR engine sharing
   the tap BRAM through the arbiter */
`timescale 1ns/1ps
`default_nettype none

module fir_top (
    input  logic           axis_clk,
    input  logic           axis_rst_n,
    input  logic           awvalid,
    input  fir_pkg::addr_t awaddr,
    output logic           awready,
    input  logic           wvalid,
    input  fir_pkg::data_t wdata,
    output logic           wready,
    input  logic           arvalid,
    input  fir_pkg::addr_t araddr,
    output logic           arready,
    output logic           rvalid,
    input  logic           rready,
    output fir_pkg::data_t rdata,
    input  logic           ss_tvalid,
    input  fir_pkg::data_t ss_tdata,
    input  logic           ss_tlast,
    output logic           ss_tready,
    input  logic           sm_tready,
    output logic           sm_tvalid,
    output fir_pkg::data_t sm_tdata,
    output logic           sm_tlast,
    output logic           tap_we,
    output fir_pkg::addr_t tap_addr,
    output fir_pkg::data_t tap_wdata,
    input  fir_pkg::data_t tap_rdata,
    output logic           data_we,
    output fir_pkg::addr_t data_addr,
    output fir_pkg::data_t data_wdata,
    input  fir_pkg::data_t data_rdata
);
    import fir_pkg::*;

    // front end to register block
    logic  cfg_wr;
    logic  cfg_rd;
    addr_t cfg_addr;
    data_t cfg_wdata;
    logic  cfg_done;
    data_t cfg_rdata;

    // tap port requests
    logic  cfg_tap_req;
    logic  cfg_tap_we;
    idx_t  cfg_tap_idx;
    data_t cfg_tap_wdata;
    logic  cfg_tap_gnt;
    logic  eng_tap_req;
    idx_t  eng_tap_idx;

    // block-level control
    logic  ap_start;
    logic  eng_started;
    logic  eng_done;

    axil_slave axil_slave_inst (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .awvalid    (awvalid),
        .awaddr     (awaddr),
        .awready    (awready),
        .wvalid     (wvalid),
        .wdata      (wdata),
        .wready     (wready),
        .arvalid    (arvalid),
        .araddr     (araddr),
        .arready    (arready),
        .rvalid     (rvalid),
        .rready     (rready),
        .rdata      (rdata),
        .cfg_wr     (cfg_wr),
        .cfg_rd     (cfg_rd),
        .cfg_addr   (cfg_addr),
        .cfg_wdata  (cfg_wdata),
        .cfg_done   (cfg_done),
        .cfg_rdata  (cfg_rdata)
    );

    cfg_regs cfg_regs_inst (
        .axis_clk      (axis_clk),
        .axis_rst_n    (axis_rst_n),
        .cfg_wr        (cfg_wr),
        .cfg_rd        (cfg_rd),
        .cfg_addr      (cfg_addr),
        .cfg_wdata     (cfg_wdata),
        .cfg_done      (cfg_done),
        .cfg_rdata     (cfg_rdata),
        .cfg_tap_req   (cfg_tap_req),
        .cfg_tap_we    (cfg_tap_we),
        .cfg_tap_idx   (cfg_tap_idx),
        .cfg_tap_wdata (cfg_tap_wdata),
        .cfg_tap_gnt   (cfg_tap_gnt),
        .tap_rdata     (tap_rdata),
        .ap_start      (ap_start),
        .eng_started   (eng_started),
        .eng_done      (eng_done)
    );

    tap_arbiter tap_arbiter_inst (
        .eng_tap_req   (eng_tap_req),
        .eng_tap_idx   (eng_tap_idx),
        .cfg_tap_req   (cfg_tap_req),
        .cfg_tap_we    (cfg_tap_we),
        .cfg_tap_idx   (cfg_tap_idx),
        .cfg_tap_wdata (cfg_tap_wdata),
        .cfg_tap_gnt   (cfg_tap_gnt),
        .tap_we        (tap_we),
        .tap_addr      (tap_addr),
        .tap_wdata     (tap_wdata)
    );

    // engine owns the data BRAM outright
    fir_engine fir_engine_inst (
        .axis_clk    (axis_clk),
        .axis_rst_n  (axis_rst_n),
        .ap_start    (ap_start),
        .eng_started (eng_started),
        .eng_done    (eng_done),
        .ss_tvalid   (ss_tvalid),
        .ss_tdata    (ss_tdata),
        .ss_tlast    (ss_tlast),
        .ss_tready   (ss_tready),
        .sm_tready   (sm_tready),
        .sm_tvalid   (sm_tvalid),
        .sm_tdata    (sm_tdata),
        .sm_tlast    (sm_tlast),
        .eng_tap_req (eng_tap_req),
        .eng_tap_idx (eng_tap_idx),
        .tap_rdata   (tap_rdata),
        .data_we     (data_we),
        .data_addr   (data_addr),
        .data_wdata  (data_wdata),
        .data_rdata  (data_rdata)
    );

endmodule

`default_nettype wire

//--- fir_engine/fir_engine.sv
/* FIR engine with sample FSM, ring-buffer history, one MAC per cycle
   and a one-deep output register on the AXI-Stream master */
`timescale 1ns/1ps
`default_nettype none

module fir_engine (
    input  logic           axis_clk,
    input  logic           axis_rst_n,
    input  logic           ap_start,
    output logic           eng_started,
    output logic           eng_done,
    input  logic           ss_tvalid,
    input  fir_pkg::data_t ss_tdata,
    input  logic           ss_tlast,
    output logic           ss_tready,
    input  logic           sm_tready,
    output logic           sm_tvalid,
    output fir_pkg::data_t sm_tdata,
    output logic           sm_tlast,
    output logic           eng_tap_req,
    output fir_pkg::idx_t  eng_tap_idx,
    input  fir_pkg::data_t tap_rdata,
    output logic           data_we,
    output fir_pkg::addr_t data_addr,
    output fir_pkg::data_t data_wdata,
    input  fir_pkg::data_t data_rdata
);
    import fir_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_WAIT,
        S_CALC,
        S_DRAIN
    } state_t;

    state_t state;
    idx_t   op_cnt;
    idx_t   head;
    idx_t   seen;
    idx_t   wr_idx;
    idx_t   hist_idx;
    idx_t   ram_idx;
    logic   accept;
    logic   last_q;
    logic   mac_vld_q;
    logic   mac_last_q;
    logic   hist_ok_q;
    logic   res_pend;
    logic   out_free;
    logic   load_out;
    data_t  x_in;
    data_t  prod;
    data_t  sum;
    data_t  acc;

    assign eng_started = (state == S_IDLE) && ap_start;
    assign eng_done    = sm_tvalid && sm_tready && sm_tlast;

    // no new sample while a finished result still waits for the output
    assign ss_tready = (state == S_WAIT) && !mac_last_q && !res_pend;
    assign accept    = ss_tvalid && ss_tready;

    // head is the newest sample, next write goes one slot further
    assign wr_idx   = (head == idx_t'(NUM_TAPS - 1)) ? '0 : head + 1'b1;
    // history for tap k is head-k around the ring
    assign hist_idx = (head >= op_cnt) ? head - op_cnt : head + idx_t'(NUM_TAPS) - op_cnt;
    assign ram_idx  = accept ? wr_idx : hist_idx;

    assign data_we    = accept;
    assign data_addr  = {{(ADDR_W - IDX_W - 2){1'b0}}, ram_idx, 2'b00};
    assign data_wdata = ss_tdata;

    // tap reads only while computing, never refused by the arbiter
    assign eng_tap_req = (state == S_CALC);
    assign eng_tap_idx = op_cnt;

    // taps beyond the samples seen this run multiply zero
    assign x_in = hist_ok_q ? data_rdata : '0;
    assign prod = tap_rdata * x_in;
    assign sum  = acc + prod;

    assign out_free = !sm_tvalid || sm_tready;
    assign load_out = (mac_last_q || res_pend) && out_free;

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            state  <= S_IDLE;
            op_cnt <= '0;
            head   <= '0;
            seen   <= '0;
            last_q <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (ap_start) begin
                        // fresh run, first sample lands in slot 0
                        head  <= idx_t'(NUM_TAPS - 1);
                        seen  <= '0;
                        state <= S_WAIT;
                    end
                end
                S_WAIT: begin
                    if (accept) begin
                        head   <= wr_idx;
                        last_q <= ss_tlast;
                        op_cnt <= '0;
                        if (seen != idx_t'(NUM_TAPS)) begin
                            seen <= seen + 1'b1;
                        end
                        state <= S_CALC;
                    end
                end
                S_CALC: begin
                    if (op_cnt == idx_t'(NUM_TAPS - 1)) begin
                        op_cnt <= '0;
                        state  <= last_q ? S_DRAIN : S_WAIT;
                    end else begin
                        op_cnt <= op_cnt + 1'b1;
                    end
                end
                default: begin
                    // final output taken, back to idle
                    if (eng_done) begin
                        state <= S_IDLE;
                    end
                end
            endcase
        end
    end

    // MAC stage sits one cycle behind the RAM addresses
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            mac_vld_q  <= 1'b0;
            mac_last_q <= 1'b0;
            hist_ok_q  <= 1'b0;
            res_pend   <= 1'b0;
        end else begin
            mac_vld_q  <= (state == S_CALC);
            mac_last_q <= (state == S_CALC) && (op_cnt == idx_t'(NUM_TAPS - 1));
            hist_ok_q  <= (op_cnt < seen);
            if (mac_last_q && !out_free) begin
                res_pend <= 1'b1;
            end else if (out_free) begin
                res_pend <= 1'b0;
            end
        end
    end

    // accumulator wraps at DATA_W, holds the full sum while the output is busy
    always_ff @(posedge axis_clk) begin
        if (accept) begin
            acc <= '0;
        end else if (mac_vld_q) begin
            acc <= sum;
        end
    end

    // output register
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            sm_tvalid <= 1'b0;
            sm_tlast  <= 1'b0;
        end else if (load_out) begin
            sm_tvalid <= 1'b1;
            sm_tlast  <= last_q;
        end else if (sm_tready) begin
            sm_tvalid <= 1'b0;
            sm_tlast  <= 1'b0;
        end
    end

    always_ff @(posedge axis_clk) begin
        if (load_out) begin
            sm_tdata <= res_pend ? acc : sum;
        end
    end

    assert property (@(posedge axis_clk) disable iff (!axis_rst_n) op_cnt < NUM_TAPS);

endmodule

`default_nettype wire

//--- logic/tap_arbiter.sv
/* single tap BRAM port shared by the engine and the config path,
   engine has fixed priority */
`timescale 1ns/1ps
`default_nettype none

module tap_arbiter (
    input  logic           eng_tap_req,
    input  fir_pkg::idx_t  eng_tap_idx,
    input  logic           cfg_tap_req,
    input  logic           cfg_tap_we,
    input  fir_pkg::idx_t  cfg_tap_idx,
    input  fir_pkg::data_t cfg_tap_wdata,
    output logic           cfg_tap_gnt,
    output logic           tap_we,
    output fir_pkg::addr_t tap_addr,
    output fir_pkg::data_t tap_wdata
);
    import fir_pkg::*;

    idx_t sel_idx;

    // config only gets the port on cycles the engine leaves free
    assign cfg_tap_gnt = cfg_tap_req && !eng_tap_req;
    assign sel_idx     = eng_tap_req ? eng_tap_idx : cfg_tap_idx;

    // tap index to word byte address
    assign tap_addr = {{(ADDR_W - IDX_W - 2){1'b0}}, sel_idx, 2'b00};

    // only a granted config write may touch the RAM
    assign tap_we    = cfg_tap_gnt && cfg_tap_we;
    assign tap_wdata = cfg_tap_wdata;

endmodule

`default_nettype wire

//--- logic/cfg_regs.sv
/* control register with ap_start/ap_done/ap_idle, address decode
   and tap access requests toward the tap arbiter */
`timescale 1ns/1ps
`default_nettype none

module cfg_regs (
    input  logic           axis_clk,
    input  logic           axis_rst_n,
    input  logic           cfg_wr,
    input  logic           cfg_rd,
    input  fir_pkg::addr_t cfg_addr,
    input  fir_pkg::data_t cfg_wdata,
    output logic           cfg_done,
    output fir_pkg::data_t cfg_rdata,
    output logic           cfg_tap_req,
    output logic           cfg_tap_we,
    output fir_pkg::idx_t  cfg_tap_idx,
    output fir_pkg::data_t cfg_tap_wdata,
    input  logic           cfg_tap_gnt,
    input  fir_pkg::data_t tap_rdata,
    output logic           ap_start,
    input  logic           eng_started,
    input  logic           eng_done
);
    import fir_pkg::*;

    logic  acc_req;
    logic  is_ctrl;
    logic  tap_hit;
    addr_t tap_off;
    logic  tap_pend;
    logic  pend_wr;
    logic  rd_gnt_q;
    logic  ap_done;
    logic  ap_idle;
    data_t ctrl_word;

    assign acc_req = cfg_wr || cfg_rd;
    assign is_ctrl = (cfg_addr == ADDR_CTRL);

    // tap word index, out-of-range words fall through to zero reads
    assign tap_off     = cfg_addr - ADDR_TAP_BASE;
    assign tap_hit     = (cfg_addr >= ADDR_TAP_BASE) && (tap_off[ADDR_W-1:2] < NUM_TAPS);
    assign cfg_tap_idx = tap_off[IDX_W+1:2];

    // level request, new strobe or one still waiting on the engine
    assign cfg_tap_req   = (acc_req && tap_hit) || tap_pend;
    assign cfg_tap_we    = acc_req ? cfg_wr : pend_wr;
    assign cfg_tap_wdata = cfg_wdata;

    // control/other accesses finish at once, tap writes on grant,
    // tap reads one cycle after grant
    assign cfg_done = (acc_req && !tap_hit) || (cfg_tap_gnt && cfg_tap_we) || rd_gnt_q;

    always_comb begin
        ctrl_word               = '0;
        ctrl_word[AP_START_BIT] = ap_start;
        ctrl_word[AP_DONE_BIT]  = ap_done;
        ctrl_word[AP_IDLE_BIT]  = ap_idle;
    end

    assign cfg_rdata = rd_gnt_q ? tap_rdata : (is_ctrl ? ctrl_word : '0);

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            tap_pend <= 1'b0;
            pend_wr  <= 1'b0;
            rd_gnt_q <= 1'b0;
        end else begin
            tap_pend <= cfg_tap_req && !cfg_tap_gnt;
            if (acc_req) begin
                pend_wr <= cfg_wr;
            end
            rd_gnt_q <= cfg_tap_gnt && !cfg_tap_we;
        end
    end

    // block-level control bits
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            ap_start <= 1'b0;
            ap_done  <= 1'b0;
            ap_idle  <= 1'b1;
        end else begin
            if (eng_started) begin
                ap_start <= 1'b0;
            end else if (cfg_wr && is_ctrl && cfg_wdata[AP_START_BIT] && ap_idle) begin
                ap_start <= 1'b1;
            end
            // a done set beats a clear-on-read in the same cycle
            if (eng_done) begin
                ap_done <= 1'b1;
            end else if (cfg_rd && is_ctrl) begin
                ap_done <= 1'b0;
            end
            if (eng_started) begin
                ap_idle <= 1'b0;
            end else if (eng_done) begin
                ap_idle <= 1'b1;
            end
        end
    end

    // the front end issues only one kind of request at a time
    assert property (@(posedge axis_clk) disable iff (!axis_rst_n) !(cfg_wr && cfg_rd));

endmodule

`default_nettype wire

//--- logic/axil_slave.sv
/* AXI-Lite slave front end, one access in flight at a time,
   turned into single-cycle config requests */
`timescale 1ns/1ps
`default_nettype none

module axil_slave (
    input  logic           axis_clk,
    input  logic           axis_rst_n,
    input  logic           awvalid,
    input  fir_pkg::addr_t awaddr,
    output logic           awready,
    input  logic           wvalid,
    input  fir_pkg::data_t wdata,
    output logic           wready,
    input  logic           arvalid,
    input  fir_pkg::addr_t araddr,
    output logic           arready,
    output logic           rvalid,
    input  logic           rready,
    output fir_pkg::data_t rdata,
    output logic           cfg_wr,
    output logic           cfg_rd,
    output fir_pkg::addr_t cfg_addr,
    output fir_pkg::data_t cfg_wdata,
    input  logic           cfg_done,
    input  fir_pkg::data_t cfg_rdata
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WR_PEND,
        ST_RD_PEND,
        ST_RD_RESP
    } state_t;

    state_t state;
    logic   wr_go;
    logic   rd_go;

    // handshake lands on the cycle the pulsed ready meets valid
    assign wr_go = awready && awvalid && wvalid;
    assign rd_go = arready && arvalid;

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            state   <= ST_IDLE;
            awready <= 1'b0;
            wready  <= 1'b0;
            arready <= 1'b0;
            rvalid  <= 1'b0;
            cfg_wr  <= 1'b0;
            cfg_rd  <= 1'b0;
        end else begin
            // readies and request strobes are one-cycle pulses
            awready <= 1'b0;
            wready  <= 1'b0;
            arready <= 1'b0;
            cfg_wr  <= 1'b0;
            cfg_rd  <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (wr_go) begin
                        cfg_wr <= 1'b1;
                        state  <= ST_WR_PEND;
                    end else if (rd_go) begin
                        cfg_rd <= 1'b1;
                        state  <= ST_RD_PEND;
                    end else if (awvalid && wvalid) begin
                        // write wins when both channels ask at once
                        awready <= 1'b1;
                        wready  <= 1'b1;
                    end else if (arvalid) begin
                        arready <= 1'b1;
                    end
                end
                ST_WR_PEND: begin
                    if (cfg_done) begin
                        state <= ST_IDLE;
                    end
                end
                ST_RD_PEND: begin
                    // data arrives with cfg_done, rvalid follows a cycle later
                    if (cfg_done) begin
                        rvalid <= 1'b1;
                        state  <= ST_RD_RESP;
                    end
                end
                default: begin
                    if (rready) begin
                        rvalid <= 1'b0;
                        state  <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    // address and data held until cfg_done
    always_ff @(posedge axis_clk) begin
        if (wr_go) begin
            cfg_addr  <= awaddr;
            cfg_wdata <= wdata;
        end else if (rd_go) begin
            cfg_addr <= araddr;
        end
        if (state == ST_RD_PEND && cfg_done) begin
            rdata <= cfg_rdata;
        end
    end

    // once offered, read data stays put until the master takes it
    assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata));

endmodule

`default_nettype wire

//--- common/fir_pkg.sv
/* widths, tap count, register map and control bit positions
   plus the word types shared by the FIR blocks */
`default_nettype none

package fir_pkg;

    // bus and datapath widths
    localparam int ADDR_W   = 12;
    localparam int DATA_W   = 32;

    // filter depth, also the sample ring depth
    localparam int NUM_TAPS = 11;
    localparam int IDX_W    = 4;

    typedef logic [ADDR_W-1:0]        addr_t;
    typedef logic signed [DATA_W-1:0] data_t;
    typedef logic [IDX_W-1:0]         idx_t;

    // AXI-Lite byte offsets, taps sit at consecutive words
    localparam addr_t ADDR_CTRL     = 12'h000;
    localparam addr_t ADDR_TAP_BASE = 12'h020;

    // control register bits
    localparam int AP_START_BIT = 0;
    localparam int AP_DONE_BIT  = 1;
    localparam int AP_IDLE_BIT  = 2;

endpackage

`default_nettype wire
